/* csr_subsystem.f */
logic/csr_pkg.sv
logic/csr_instr_decode.sv
logic/csr_counters.sv
logic/csr_machine.sv
logic/csr_file.sv
logic/csr_subsystem.sv
bench/csr_subsystem_tb.sv

/* Bender.yml */
package:
  name: csr_subsystem

sources:
  - logic/csr_pkg.sv
  - logic/csr_instr_decode.sv
  - logic/csr_counters.sv
  - logic/csr_machine.sv
  - logic/csr_file.sv
  - logic/csr_subsystem.sv
  - target: simulation
    files:
      - bench/csr_subsystem_tb.sv

/* bench/csr_subsystem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_subsystem_tb;

    // Instructions issued over all tests add up as 17 + 12 + 6 + 14 + 4.
    localparam int N_INSTR        = 53;
    localparam int TIMEOUT_CYCLES = N_INSTR * 4 + 200;
    localparam logic [31:0] MSTATUS_MASK = (32'd1 << csr_pkg::MSTATUS_MIE_BIT) |
                                           (32'd1 << csr_pkg::MSTATUS_MPIE_BIT);

    logic        i_clk;
    logic        i_rst_n;
    logic        i_valid;
    logic        i_kill;
    logic [31:0] i_instr;
    logic [31:0] i_rs1_data;
    logic [31:1] i_pc;
    logic        i_retire;
    logic        o_rd_valid;
    logic [31:0] o_rd_data;
    logic        o_trap;
    logic [31:1] o_trap_pc;
    logic [31:1] o_ret_addr;

    csr_subsystem csr_subsystem_i
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (i_valid),
        .i_kill     (i_kill),
        .i_instr    (i_instr),
        .i_rs1_data (i_rs1_data),
        .i_pc       (i_pc),
        .i_retire   (i_retire),
        .o_rd_valid (o_rd_valid),
        .o_rd_data  (o_rd_data),
        .o_trap     (o_trap),
        .o_trap_pc  (o_trap_pc),
        .o_ret_addr (o_ret_addr)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference state, expectation queues and helpers.

    logic [31:0] ref_mstatus, ref_mtvec, ref_mscratch, ref_mepc, ref_mcause;
    logic [63:0] retire_count;
    logic [31:0] rng_state;
    logic [31:0] prev_rs1;
    int          exp_kind[$];  // 0 read, 1 trap, 2 cycle delta, 3 cycle base.
    logic [31:0] exp_val[$];
    string       exp_name[$];
    int          checks;
    int          errors;
    int          cycles;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Returns the old value and commits the effect, in issue order.
    function automatic logic [31:0] ref_exec(input csr_pkg::csr_op_e op, input logic [11:0] idx,
                                             input logic [31:0] wval, input logic wr,
                                             input logic [31:0] pc);
        logic [31:0] old;
        logic [31:0] nv;
        logic [31:0] ms;
        case (idx)
            csr_pkg::CSR_MSTATUS:  old = ref_mstatus;
            csr_pkg::CSR_MTVEC:    old = ref_mtvec;
            csr_pkg::CSR_MSCRATCH: old = ref_mscratch;
            csr_pkg::CSR_MEPC:     old = ref_mepc;
            csr_pkg::CSR_MCAUSE:   old = ref_mcause;
            csr_pkg::CSR_INSTRET:  old = retire_count[31:0];
            csr_pkg::CSR_INSTRETH: old = retire_count[63:32];
            default:               old = '0;
        endcase
        if (op == csr_pkg::CSR_EBREAK)
        begin
            ms = '0;
            ms[csr_pkg::MSTATUS_MPIE_BIT] = ref_mstatus[csr_pkg::MSTATUS_MIE_BIT];
            ref_mstatus = ms;
            ref_mepc    = pc & ~32'd1;
            ref_mcause  = csr_pkg::CAUSE_BREAKPOINT;
            return ref_mtvec; // The trap reports the handler address.
        end
        case (op)
            csr_pkg::CSR_RS: nv = old | wval;
            csr_pkg::CSR_RC: nv = old & ~wval;
            default:         nv = wval;
        endcase
        if (wr)
        begin
            case (idx)
                csr_pkg::CSR_MSTATUS:  ref_mstatus  = nv & MSTATUS_MASK;
                csr_pkg::CSR_MTVEC:    ref_mtvec    = nv & ~32'd3;
                csr_pkg::CSR_MSCRATCH: ref_mscratch = nv;
                csr_pkg::CSR_MEPC:     ref_mepc     = nv & ~32'd1;
                csr_pkg::CSR_MCAUSE:   ref_mcause   = nv;
                default:               ;
            endcase
        end
        return old;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("[FAIL] %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    task automatic push_expect(input int kind, input logic [31:0] val, input string name);
        exp_kind.push_back(kind);
        exp_val.push_back(val);
        exp_name.push_back(name);
    endtask

    // The source operand trails its instruction by one cycle.
    task automatic issue(input logic [31:0] instr, input logic [31:0] rs1, input logic [31:0] pc,
                         input logic kill);
        @(posedge i_clk);
        i_valid    <= 1'b1;
        i_kill     <= kill;
        i_instr    <= instr;
        i_pc       <= pc[31:1];
        i_rs1_data <= prev_rs1;
        prev_rs1 = rs1;
    endtask

    task automatic idle();
        @(posedge i_clk);
        i_valid    <= 1'b0;
        i_kill     <= 1'b0;
        i_instr    <= '0;
        i_rs1_data <= prev_rs1;
        prev_rs1 = '0;
    endtask

    task automatic run_csr(input string name, input logic [2:0] f3, input logic [11:0] idx,
                           input logic [4:0] rs1f, input logic [4:0] rd,
                           input logic [31:0] rs1val, input logic kill);
        csr_pkg::csr_op_e op;
        logic [31:0]      wval;
        logic [31:0]      old;
        logic             wr;
        logic             rd_en;
        case (f3[1:0])
            2'b01:   op = csr_pkg::CSR_RW;
            2'b10:   op = csr_pkg::CSR_RS;
            default: op = csr_pkg::CSR_RC;
        endcase
        wval  = f3[2] ? {27'd0, rs1f} : rs1val;
        wr    = (op == csr_pkg::CSR_RW) || (rs1f != 5'd0);
        rd_en = (op != csr_pkg::CSR_RW) || (rd != 5'd0);
        issue({idx, rs1f, f3, rd, 7'b1110011}, rs1val, 32'd0, kill);
        if (!kill)
        begin
            old = ref_exec(op, idx, wval, wr, 32'd0);
            if (rd_en)
                push_expect(0, old, name);
        end
    endtask

    task automatic run_ebreak(input logic [31:0] pc, input logic kill);
        logic [31:0] old;
        issue(32'h0010_0073, 32'd0, pc, kill);
        if (!kill)
        begin
            old = ref_exec(csr_pkg::CSR_EBREAK, 12'd0, 32'd0, 1'b0, pc);
            push_expect(1, old, "trap_pc");
        end
    endtask

    task automatic read_cycle(input int kind, input logic [31:0] delta);
        issue({csr_pkg::CSR_CYCLE, 5'd0, 3'b010, 5'd5, 7'b1110011}, 32'd0, 32'd0, 1'b0);
        push_expect(kind, delta, "cycle_delta");
    endtask

    task automatic finish_test(input string name);
        idle();
        while (exp_kind.size() != 0)
            idle();
        repeat (3) idle(); // Room for a stray strobe to show up.
        $display("[DONE] %s: %0d checks, %0d errors so far", name, checks, errors);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // The compare process samples away from the driving edge.

    initial
    begin : compare
        int          kind;
        logic [31:0] val;
        string       name;
        logic [31:0] cycle_base;
        cycle_base = '0;
        forever
        begin
            @(negedge i_clk);
            if (o_rd_valid || o_trap)
            begin
                if (exp_kind.size() == 0)
                begin
                    errors++;
                    $display("The DUT gave a read or trap strobe that no instruction asked for.");
                end
                else
                begin
                    kind = exp_kind.pop_front();
                    val  = exp_val.pop_front();
                    name = exp_name.pop_front();
                    if (kind == 1 && !o_trap)
                    begin
                        errors++;
                        $display("%s: a trap was expected but the DUT gave a read.", name);
                    end
                    else if (kind == 1)
                        check(name, val, {o_trap_pc, 1'b0});
                    else if (!o_rd_valid)
                    begin
                        errors++;
                        $display("%s: a read was expected but the DUT raised a trap.", name);
                    end
                    else if (kind == 3)
                        cycle_base = o_rd_data;
                    else if (kind == 2)
                        check(name, val, o_rd_data - cycle_base);
                    else
                        check(name, val, o_rd_data);
                end
            end
        end
    end

    initial
    begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge i_clk);
            cycles++;
        end
        $display("Timeout: the run did not end within %0d cycles.", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus.

    initial
    begin
        int          i;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        i_rst_n    = 1'b0;
        i_valid    = 1'b0;
        i_kill     = 1'b0;
        i_instr    = '0;
        i_rs1_data = '0;
        i_pc       = '0;
        i_retire   = 1'b0;
        {ref_mstatus, ref_mtvec, ref_mscratch, ref_mepc, ref_mcause} = '0;
        retire_count = '0;
        rng_state    = 32'h2c03_3cd9;
        prev_rs1     = '0;
        checks       = 0;
        errors       = 0;
        repeat (5) @(posedge i_clk);
        i_rst_n <= 1'b1;

        for (i = 0; i < 16; i++)
            run_csr("mscratch_rw", 3'b001, csr_pkg::CSR_MSCRATCH, 5'd6, 5'd5, rand32(), 1'b0);
        run_csr("mscratch_rw", 3'b010, csr_pkg::CSR_MSCRATCH, 5'd0, 5'd5, 32'd0, 1'b0);
        finish_test("mscratch_rw");

        run_csr("mstatus_rs", 3'b010, csr_pkg::CSR_MSTATUS, 5'd6, 5'd5, '1, 1'b0);
        run_csr("mstatus_rc_x0", 3'b011, csr_pkg::CSR_MSTATUS, 5'd0, 5'd5, '1, 1'b0);
        run_csr("mstatus_rci", 3'b111, csr_pkg::CSR_MSTATUS, 5'd8, 5'd5, '0, 1'b0);
        run_csr("mstatus_rs_x0", 3'b010, csr_pkg::CSR_MSTATUS, 5'd0, 5'd5, '1, 1'b0);
        run_csr("mstatus_rd", 3'b010, csr_pkg::CSR_MSTATUS, 5'd0, 5'd5, '0, 1'b0);
        run_csr("mtvec_rw", 3'b001, csr_pkg::CSR_MTVEC, 5'd6, 5'd0, rand32(), 1'b0);
        run_csr("mtvec_rsi", 3'b110, csr_pkg::CSR_MTVEC, 5'd3, 5'd5, '0, 1'b0);
        run_csr("mtvec_rc", 3'b011, csr_pkg::CSR_MTVEC, 5'd6, 5'd5, rand32(), 1'b0);
        run_csr("mtvec_rs", 3'b010, csr_pkg::CSR_MTVEC, 5'd6, 5'd5, rand32(), 1'b0);
        run_csr("mtvec_rc_x0", 3'b011, csr_pkg::CSR_MTVEC, 5'd0, 5'd5, '1, 1'b0);
        run_csr("mtvec_rwi", 3'b101, csr_pkg::CSR_MTVEC, 5'h1f, 5'd5, '0, 1'b0);
        run_csr("mtvec_rd", 3'b010, csr_pkg::CSR_MTVEC, 5'd0, 5'd5, '0, 1'b0);
        finish_test("set_clear");

        run_csr("mtvec_rw", 3'b001, csr_pkg::CSR_MTVEC, 5'd6, 5'd0, rand32(), 1'b0);
        run_csr("mstatus_rsi", 3'b110, csr_pkg::CSR_MSTATUS, 5'd8, 5'd5, '0, 1'b0);
        run_ebreak(rand32(), 1'b0);
        run_csr("mepc_rd", 3'b010, csr_pkg::CSR_MEPC, 5'd0, 5'd5, '0, 1'b0);
        run_csr("mcause_rd", 3'b010, csr_pkg::CSR_MCAUSE, 5'd0, 5'd5, '0, 1'b0);
        run_csr("mstatus_rd", 3'b010, csr_pkg::CSR_MSTATUS, 5'd0, 5'd5, '0, 1'b0);
        finish_test("breakpoint_pre");
        @(negedge i_clk);
        check("ret_addr", ref_mepc, {o_ret_addr, 1'b0});
        $display("[DONE] breakpoint: %0d checks, %0d errors so far", checks, errors);

        a = rand32();
        b = rand32();
        run_csr("mscratch_rw", 3'b001, csr_pkg::CSR_MSCRATCH, 5'd6, 5'd5, a, 1'b0);
        finish_test("kill_setup");
        run_csr("killed_rw", 3'b001, csr_pkg::CSR_MSCRATCH, 5'd6, 5'd5, b, 1'b1);
        run_ebreak(rand32(), 1'b1);
        run_csr("killed_rsi", 3'b110, csr_pkg::CSR_MSTATUS, 5'd8, 5'd5, '0, 1'b1);
        finish_test("killed");
        run_csr("cycle_wr", 3'b001, csr_pkg::CSR_CYCLE, 5'd6, 5'd0, b, 1'b0);
        run_csr("instreth_wr", 3'b001, csr_pkg::CSR_INSTRETH, 5'd6, 5'd0, b, 1'b0);
        run_csr("unknown_wr", 3'b001, 12'h3FF, 5'd6, 5'd0, b, 1'b0);
        run_csr("super_wr", 3'b001, 12'h100, 5'd6, 5'd0, b, 1'b0);
        run_csr("mscratch_rd", 3'b010, csr_pkg::CSR_MSCRATCH, 5'd0, 5'd5, '0, 1'b0);
        run_csr("super_rd", 3'b010, 12'h100, 5'd0, 5'd5, '0, 1'b0);
        run_csr("hyper_rd", 3'b010, 12'h200, 5'd0, 5'd5, '0, 1'b0);
        run_csr("unknown_rd", 3'b010, 12'h3FF, 5'd0, 5'd5, '0, 1'b0);
        run_csr("mstatus_rd", 3'b010, csr_pkg::CSR_MSTATUS, 5'd0, 5'd5, '0, 1'b0);
        run_csr("mepc_rd", 3'b010, csr_pkg::CSR_MEPC, 5'd0, 5'd5, '0, 1'b0);
        finish_test("ignored_writes");

        read_cycle(3, 32'd0);
        repeat (6) idle();
        read_cycle(2, 32'd7); // Issued seven cycles after the first.
        finish_test("cycle");
        for (i = 0; i < 40; i++)
        begin
            r = rand32();
            @(posedge i_clk);
            i_retire <= r[0];
            retire_count = retire_count + r[0];
        end
        @(posedge i_clk);
        i_retire <= 1'b0;
        run_csr("instret_rd", 3'b010, csr_pkg::CSR_INSTRET, 5'd0, 5'd5, '0, 1'b0);
        run_csr("instreth_rd", 3'b010, csr_pkg::CSR_INSTRETH, 5'd0, 5'd5, '0, 1'b0);
        finish_test("instret");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/csr_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_subsystem
#(
    parameter int PC_BITS      = 32,
    parameter bit HAS_COUNTERS = 1
)
(
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_valid,
    input  logic               i_kill,
    input  logic [31:0]        i_instr,
    input  logic [31:0]        i_rs1_data,  // Lags i_instr by one cycle.
    input  logic [PC_BITS-1:1] i_pc,
    input  logic               i_retire,
    output logic               o_rd_valid,
    output logic [31:0]        o_rd_data,
    output logic               o_trap,
    output logic [PC_BITS-1:1] o_trap_pc,
    output logic [PC_BITS-1:1] o_ret_addr
);

    logic               dec_valid;
    logic [11:0]        dec_idx;
    logic [4:0]         dec_imm;
    logic               dec_imm_sel;
    csr_pkg::csr_op_e   dec_op;
    logic               dec_rd_en;
    logic               dec_wr_en;

    csr_instr_decode u_decode
    (
        .i_instr   (i_instr),
        .i_valid   (i_valid),
        .i_kill    (i_kill),
        .o_valid   (dec_valid),
        .o_idx     (dec_idx),
        .o_imm     (dec_imm),
        .o_imm_sel (dec_imm_sel),
        .o_op      (dec_op),
        .o_rd_en   (dec_rd_en),
        .o_wr_en   (dec_wr_en)
    );

    csr_file
    #(
        .PC_BITS      (PC_BITS),
        .HAS_COUNTERS (HAS_COUNTERS)
    )
    u_file
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (dec_valid),
        .i_idx      (dec_idx),
        .i_imm      (dec_imm),
        .i_imm_sel  (dec_imm_sel),
        .i_op       (dec_op),
        .i_rd_en    (dec_rd_en),
        .i_wr_en    (dec_wr_en),
        .i_rs1_data (i_rs1_data),
        .i_pc       (i_pc),
        .i_retire   (i_retire),
        .o_rd_valid (o_rd_valid),
        .o_rd_data  (o_rd_data),
        .o_trap     (o_trap),
        .o_trap_pc  (o_trap_pc),
        .o_ret_addr (o_ret_addr)
    );

endmodule

`default_nettype wire

/* logic/csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_file
#(
    parameter int PC_BITS      = 32,
    parameter bit HAS_COUNTERS = 1
)
(
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_valid,
    input  logic [11:0]        i_idx,
    input  logic [4:0]         i_imm,
    input  logic               i_imm_sel,
    input  csr_pkg::csr_op_e   i_op,
    input  logic               i_rd_en,
    input  logic               i_wr_en,
    input  logic [31:0]        i_rs1_data,
    input  logic [PC_BITS-1:1] i_pc,
    input  logic               i_retire,
    output logic               o_rd_valid,
    output logic [31:0]        o_rd_data,
    output logic               o_trap,
    output logic [PC_BITS-1:1] o_trap_pc,
    output logic [PC_BITS-1:1] o_ret_addr
);

    logic               buf_valid, exec_valid;
    logic               buf_rd_en, exec_rd_en;
    logic               buf_wr_en, exec_wr_en;
    csr_pkg::csr_op_e   buf_op, exec_op;
    logic [11:0]        buf_idx, exec_idx;
    logic [4:0]         buf_imm, exec_imm;
    logic               buf_imm_sel, exec_imm_sel;
    logic [PC_BITS-1:1] buf_pc, exec_pc;
    logic [31:0]        exec_rs1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Two-stage command pipeline.

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            buf_valid  <= 1'b0;
            buf_rd_en  <= 1'b0;
            buf_wr_en  <= 1'b0;
            buf_op     <= csr_pkg::CSR_NONE;
            exec_valid <= 1'b0;
            exec_rd_en <= 1'b0;
            exec_wr_en <= 1'b0;
            exec_op    <= csr_pkg::CSR_NONE;
        end
        else
        begin
            buf_valid  <= i_valid;
            buf_rd_en  <= i_rd_en;
            buf_wr_en  <= i_wr_en;
            buf_op     <= i_op;
            exec_valid <= buf_valid;
            exec_rd_en <= buf_rd_en;
            exec_wr_en <= buf_wr_en;
            exec_op    <= buf_op;
        end
    end

    always_ff @(posedge i_clk)
    begin
        buf_idx      <= i_idx;
        buf_imm      <= i_imm;
        buf_imm_sel  <= i_imm_sel;
        buf_pc       <= i_pc;
        exec_idx     <= buf_idx;
        exec_imm     <= buf_imm;
        exec_imm_sel <= buf_imm_sel;
        exec_pc      <= buf_pc;
        exec_rs1     <= i_rs1_data;  // Operand arrives one cycle after the command.
    end

    logic [31:0] write_value;
    logic [31:0] pc_full;
    logic        machine_sel;
    logic [31:0] rdata_user, rdata_machine;
    logic [31:0] mtvec, mepc;

    assign write_value = exec_imm_sel ? {27'd0, exec_imm} : exec_rs1;
    assign pc_full     = 32'({exec_pc, 1'b0});
    assign machine_sel = (exec_idx[9:8] == 2'b11);

    generate
        if (HAS_COUNTERS)
        begin : g_counters
            csr_counters u_counters
            (
                .i_clk    (i_clk),
                .i_rst_n  (i_rst_n),
                .i_idx    (exec_idx[7:0]),
                .i_retire (i_retire),
                .o_data   (rdata_user)
            );
        end
        else
        begin : g_no_counters
            assign rdata_user = '0;
        end
    endgenerate

    csr_machine u_machine
    (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_sel   (machine_sel),
        .i_valid (exec_valid),
        .i_op    (exec_op),
        .i_wr_en (exec_wr_en),
        .i_idx   (exec_idx[7:0]),
        .i_data  (write_value),
        .i_pc    (pc_full),
        .o_data  (rdata_machine),
        .o_mtvec (mtvec),
        .o_mepc  (mepc)
    );

    always_comb
    begin
        case (exec_idx[9:8])
            2'b00:   o_rd_data = rdata_user;
            2'b11:   o_rd_data = rdata_machine;
            default: o_rd_data = '0; // Supervisor and hypervisor space is empty.
        endcase
    end

    assign o_rd_valid = exec_valid && exec_rd_en;
    assign o_trap     = exec_valid && (exec_op == csr_pkg::CSR_EBREAK);
    assign o_trap_pc  = mtvec[PC_BITS-1:1];
    assign o_ret_addr = mepc[PC_BITS-1:1];

endmodule

`default_nettype wire

/* logic/csr_machine.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_machine
(
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_sel,
    input  logic               i_valid,
    input  csr_pkg::csr_op_e   i_op,
    input  logic               i_wr_en,
    input  logic [7:0]         i_idx,
    input  logic [31:0]        i_data,
    input  logic [31:0]        i_pc,
    output logic [31:0]        o_data,
    output logic [31:0]        o_mtvec,
    output logic [31:0]        o_mepc
);

    logic        mie;
    logic        mpie;
    logic [31:2] mtvec;
    logic [31:0] mscratch;
    logic [31:1] mepc;
    logic [31:0] mcause;

    logic [31:0] mstatus_val;
    logic [31:0] new_value;
    logic        is_csr_op;
    logic        wr_hit;
    logic        trap_hit;

    always_comb
    begin
        mstatus_val = '0;
        mstatus_val[csr_pkg::MSTATUS_MIE_BIT]  = mie;
        mstatus_val[csr_pkg::MSTATUS_MPIE_BIT] = mpie;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // The read port also supplies the old value for set and clear.

    always_comb
    begin
        case (i_idx)
            csr_pkg::CSR_MSTATUS[7:0]:  o_data = mstatus_val;
            csr_pkg::CSR_MTVEC[7:0]:    o_data = {mtvec, 2'b00};
            csr_pkg::CSR_MSCRATCH[7:0]: o_data = mscratch;
            csr_pkg::CSR_MEPC[7:0]:     o_data = {mepc, 1'b0};
            csr_pkg::CSR_MCAUSE[7:0]:   o_data = mcause;
            default:                    o_data = '0;
        endcase
    end

    always_comb
    begin
        case (i_op)
            csr_pkg::CSR_RS: new_value = o_data | i_data;
            csr_pkg::CSR_RC: new_value = o_data & ~i_data;
            default:         new_value = i_data;
        endcase
    end

    assign is_csr_op = (i_op == csr_pkg::CSR_RW) || (i_op == csr_pkg::CSR_RS) ||
                       (i_op == csr_pkg::CSR_RC);
    assign wr_hit    = i_valid && i_sel && i_wr_en && is_csr_op;
    assign trap_hit  = i_valid && (i_op == csr_pkg::CSR_EBREAK);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register update.

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            mie      <= 1'b0;
            mpie     <= 1'b0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end
        else if (trap_hit)
        begin
            mepc   <= i_pc[31:1];
            mcause <= csr_pkg::CAUSE_BREAKPOINT;
            mpie   <= mie;  // Interrupts stay off inside the handler.
            mie    <= 1'b0;
        end
        else if (wr_hit)
        begin
            case (i_idx)
                csr_pkg::CSR_MSTATUS[7:0]:
                begin
                    mie  <= new_value[csr_pkg::MSTATUS_MIE_BIT];
                    mpie <= new_value[csr_pkg::MSTATUS_MPIE_BIT];
                end
                csr_pkg::CSR_MTVEC[7:0]:    mtvec    <= new_value[31:2]; // Direct mode only.
                csr_pkg::CSR_MSCRATCH[7:0]: mscratch <= new_value;
                csr_pkg::CSR_MEPC[7:0]:     mepc     <= new_value[31:1];
                csr_pkg::CSR_MCAUSE[7:0]:   mcause   <= new_value;
                default:
                begin
                    // Unknown addresses drop the write.
                end
            endcase
        end
    end

    assign o_mtvec = {mtvec, 2'b00};
    assign o_mepc  = {mepc, 1'b0};

endmodule

`default_nettype wire

/* logic/csr_counters.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_counters
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic [7:0]  i_idx,
    input  logic        i_retire,
    output logic [31:0] o_data
);

    logic [63:0] cycle;
    logic [63:0] instret;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Free-running counters.

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            cycle <= '0;
        end
        else
        begin
            cycle <= cycle + 64'd1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            instret <= '0;
        end
        else if (i_retire)
        begin
            instret <= instret + 64'd1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read port.

    always_comb
    begin
        case (i_idx)
            csr_pkg::CSR_CYCLE[7:0]:    o_data = cycle[31:0];
            csr_pkg::CSR_INSTRET[7:0]:  o_data = instret[31:0];
            csr_pkg::CSR_CYCLEH[7:0]:   o_data = cycle[63:32];
            csr_pkg::CSR_INSTRETH[7:0]: o_data = instret[63:32];
            default:                    o_data = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/csr_instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_instr_decode
(
    input  logic [31:0]        i_instr,
    input  logic               i_valid,
    input  logic               i_kill,
    output logic               o_valid,
    output logic [11:0]        o_idx,
    output logic [4:0]         o_imm,
    output logic               o_imm_sel,
    output csr_pkg::csr_op_e   o_op,
    output logic               o_rd_en,
    output logic               o_wr_en
);

    localparam logic [6:0]  OPC_SYSTEM = 7'b1110011;
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    logic [2:0] funct3;
    logic       rd_zero;
    logic       rs1_zero;
    logic       is_system;

    assign funct3    = i_instr[14:12];
    assign rd_zero   = (i_instr[11:7] == 5'd0);
    assign rs1_zero  = (i_instr[19:15] == 5'd0);
    assign is_system = (i_instr[6:0] == OPC_SYSTEM);

    assign o_idx     = i_instr[31:20];
    assign o_imm     = i_instr[19:15]; // The rs1 field doubles as zimm.
    assign o_imm_sel = funct3[2];

    always_comb
    begin
        o_op    = csr_pkg::CSR_NONE;
        o_rd_en = 1'b0;
        o_wr_en = 1'b0;
        if (i_instr == EBREAK_WORD)
        begin
            o_op = csr_pkg::CSR_EBREAK;
        end
        else if (is_system)
        begin
            case (funct3[1:0])
                2'b01:
                begin
                    o_op    = csr_pkg::CSR_RW;
                    o_rd_en = !rd_zero; // A write to x0 skips the read side effects.
                    o_wr_en = 1'b1;
                end
                2'b10:
                begin
                    o_op    = csr_pkg::CSR_RS;
                    o_rd_en = 1'b1;
                    o_wr_en = !rs1_zero;
                end
                2'b11:
                begin
                    o_op    = csr_pkg::CSR_RC;
                    o_rd_en = 1'b1;
                    o_wr_en = !rs1_zero;
                end
                default:
                begin
                    o_op = csr_pkg::CSR_NONE; // ecall, mret, wfi and friends.
                end
            endcase
        end
    end

    assign o_valid = i_valid && !i_kill && (o_op != csr_pkg::CSR_NONE);

endmodule

`default_nettype wire

/* logic/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    // Operation carried down the CSR pipeline.
    typedef enum logic [2:0]
    {
        CSR_NONE   = 3'd0,
        CSR_RW     = 3'd1,
        CSR_RS     = 3'd2,
        CSR_RC     = 3'd3,
        CSR_EBREAK = 3'd4
    } csr_op_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Machine-level registers.
    localparam logic [11:0] CSR_MSTATUS  = 12'h300;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // User-level read-only counters.
    localparam logic [11:0] CSR_CYCLE    = 12'hC00;
    localparam logic [11:0] CSR_INSTRET  = 12'hC02;
    localparam logic [11:0] CSR_CYCLEH   = 12'hC80;
    localparam logic [11:0] CSR_INSTRETH = 12'hC82;

    // Exception code written to mcause on ebreak.
    localparam logic [31:0] CAUSE_BREAKPOINT = 32'd3;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

endpackage

`default_nettype wire
